// ==== logic/ack_sender.sv ====
// Acknowledgement sender, turns each response into its ASCII string and feeds the transmitter
`timescale 1ns/10ps

module ack_sender import if_ext_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    resp_if.sink  resp,
    input  logic  tx_full,
    output byte_t ack_byte,
    output logic  ack_valid
);

    localparam byte_t       CR          = 8'h0D;
    localparam byte_t       LF          = 8'h0A;
    localparam logic [63:0] STR_WRITE   = "WRITE+OK";
    localparam logic [63:0] STR_READ    = "READ+OK:";
    localparam logic [63:0] STR_TIMEOUT = {"TIMEOUT", CR};   // Padded to eight bytes

    logic       busy;
    logic [1:0] kind_q;
    byte_t      data_q;
    logic [3:0] idx;
    logic [3:0] last_idx;       // Position of LF

    function automatic byte_t pick(input logic [63:0] str, input logic [2:0] pos);
        pick = str[8*(7-pos) +: 8];
    endfunction

    assign resp.resp_ready = !busy;
    assign ack_valid       = busy && !tx_full;

    always_comb begin
        case (kind_q)
            RESP_READ_OK: last_idx = 4'd10;
            RESP_TIMEOUT: last_idx = 4'd8;
            default:      last_idx = 4'd9;
        endcase
    end

    // ----------------------------------------
    // String byte at the current position
    // ----------------------------------------
    always_comb begin
        case (kind_q)
            RESP_READ_OK: begin
                if (idx < 4'd8)
                    ack_byte = pick(STR_READ, idx[2:0]);
                else if (idx == 4'd8)
                    ack_byte = data_q;   // Raw read byte
                else if (idx == 4'd9)
                    ack_byte = CR;
                else
                    ack_byte = LF;
            end
            RESP_TIMEOUT: ack_byte = (idx < 4'd8) ? pick(STR_TIMEOUT, idx[2:0]) : LF;
            default: begin
                if (idx < 4'd8)
                    ack_byte = pick(STR_WRITE, idx[2:0]);
                else
                    ack_byte = (idx == 4'd8) ? CR : LF;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            idx    <= 4'd0;
            kind_q <= RESP_WRITE_OK;
        end else if (!busy) begin
            if (resp.resp_valid) begin
                busy   <= 1'b1;
                idx    <= 4'd0;
                kind_q <= resp.kind;
            end
        end else if (!tx_full) begin
            idx <= idx + 4'd1;
            if (idx == last_idx)
                busy <= 1'b0;   // LF out, ready for the next response
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && resp.resp_valid)
            data_q <= resp.rdata;
    end

endmodule

// ==== logic/cmd_collector.sv ====
// Receive side, fetches link bytes, decodes opcodes and gathers operands into cmd_if
`timescale 1ns/10ps

module cmd_collector import if_ext_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              data_valid,
    input  logic              data_ready,
    input  byte_t             data_byte,
    output logic              get_data,
    input  logic [TIME_W-1:0] opds_time,
    cmd_if.source             cmd
);

    logic              pending;     // Request out, byte not back yet
    logic              gathering;   // Opcode taken, operands still due
    logic [1:0]        opd_got;
    logic [TIME_W-1:0] opd_timer;
    opcode_u           rx_op;

    assign rx_op = data_byte;

    function automatic logic known_opcode(input opcode_u op);
        case (op.raw)
            OPC_INTERREGW, OPC_INTERREGR,
            OPC_GLOBALREGW, OPC_GLOBALREGR,
            OPC_JPEGREGW, OPC_JPEGREGR,
            OPC_DISPLAYREGW, OPC_DISPLAYREGR,
            OPC_SENSREGW, OPC_SENSREGR: known_opcode = 1'b1;
            default:                    known_opcode = 1'b0;
        endcase
    endfunction

    // ----------------------------------------
    // Byte requests
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            get_data <= 1'b0;
            pending  <= 1'b0;
        end else begin
            get_data <= 1'b0;
            if (data_ready) begin
                pending <= 1'b0;
            end else if (data_valid && !pending && !cmd.cmd_valid) begin
                get_data <= 1'b1;   // Held off while a command waits
                pending  <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Decode, gather and operand timeout
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gathering     <= 1'b0;
            opd_got       <= 2'd0;
            opd_timer     <= '0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            if (cmd.cmd_valid && cmd.cmd_ready)
                cmd.cmd_valid <= 1'b0;
            if (data_ready) begin
                opd_timer <= '0;
                if (!gathering) begin
                    gathering <= known_opcode(rx_op);   // Unknown byte just dropped
                    opd_got   <= 2'd0;
                end else begin
                    opd_got <= opd_got + 2'd1;
                    if ((opd_got + 2'd1) == cmd.opcode.f.opd_count[1:0]) begin
                        gathering     <= 1'b0;
                        cmd.cmd_valid <= 1'b1;
                    end
                end
            end else if (gathering) begin
                if (opd_timer == opds_time)
                    gathering <= 1'b0;   // Partial command lost, no response
                else
                    opd_timer <= opd_timer + 1'b1;
            end
        end
    end

    // Command fields, stable while cmd_valid is up
    always_ff @(posedge clk) begin
        if (data_ready) begin
            if (!gathering)
                cmd.opcode <= rx_op;
            else if (opd_got == 2'd0)
                cmd.addr <= data_byte;
            else
                cmd.wdata <= data_byte;
        end
    end

endmodule

// ==== logic/cmd_executor.sv ====
// Command dispatcher, serves interface registers locally and block registers as Wishbone master
`timescale 1ns/10ps

module cmd_executor import if_ext_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    cmd_if.sink               cmd,
    resp_if.source            resp,
    output logic              reg_we,
    output reg_addr_t         reg_addr,
    output byte_t             reg_wdata,
    input  byte_t             reg_rdata,
    input  logic [TIME_W-1:0] delay_time,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output bus_addr_t         wb_adr,
    output byte_t             wb_wdata,
    input  byte_t             wb_rdata,
    input  logic              wb_ack
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_BUS  = 2'd1;   // Bus cycle open
    localparam logic [1:0] S_RESP = 2'd2;   // Response offered

    logic [1:0]        state;
    logic [TIME_W-1:0] delay_cnt;
    logic              accept;
    logic              is_write;
    logic              is_inter;
    logic [1:0]        blk;

    assign cmd.cmd_ready = (state == S_IDLE);
    assign accept        = cmd.cmd_valid && cmd.cmd_ready;
    assign is_write      = (cmd.opcode.f.opd_count == 4'd2);
    assign is_inter      = (cmd.opcode.f.cmd_code[3:1] == 3'b000);  // Codes 0 and 1

    // Block offset from the command code
    always_comb begin
        case (cmd.opcode.f.cmd_code)
            4'h2, 4'h3: blk = B_GLOBAL;
            4'h4, 4'h5: blk = B_JPEG;
            4'h6, 4'h7: blk = B_DISPLAY;
            default:    blk = B_SENS;
        endcase
    end

    // Local register port, active in the accept cycle
    assign reg_we    = accept && is_inter && is_write;
    assign reg_addr  = cmd.addr;
    assign reg_wdata = cmd.wdata;

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= S_IDLE;
            delay_cnt       <= '0;
            wb_cyc          <= 1'b0;
            wb_stb          <= 1'b0;
            wb_we           <= 1'b0;
            resp.resp_valid <= 1'b0;
            resp.kind       <= RESP_WRITE_OK;
        end else begin
            case (state)
                S_IDLE: begin
                    delay_cnt <= '0;
                    if (accept && is_inter) begin
                        state           <= S_RESP;
                        resp.resp_valid <= 1'b1;
                        resp.kind       <= is_write ? RESP_WRITE_OK : RESP_READ_OK;
                    end else if (accept) begin
                        state  <= S_BUS;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= is_write;
                    end
                end
                S_BUS: begin
                    if (wb_ack || delay_cnt == delay_time) begin
                        state           <= S_RESP;
                        wb_cyc          <= 1'b0;
                        wb_stb          <= 1'b0;
                        wb_we           <= 1'b0;
                        resp.resp_valid <= 1'b1;
                        if (!wb_ack)
                            resp.kind <= RESP_TIMEOUT;   // Target never answered
                        else
                            resp.kind <= wb_we ? RESP_WRITE_OK : RESP_READ_OK;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                S_RESP: begin
                    if (resp.resp_ready) begin
                        resp.resp_valid <= 1'b0;
                        state           <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Bus address, write data and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_adr   <= {blk, cmd.addr};
            wb_wdata <= cmd.wdata;
        end
        if (accept && is_inter)
            resp.rdata <= reg_rdata;
        else if (state == S_BUS && wb_ack)
            resp.rdata <= wb_rdata;
    end

endmodule

// ==== logic/cmd_if.sv ====
// Decoded command channel, connects the collector (source) to the executor (sink)
`timescale 1ns/10ps

interface cmd_if import if_ext_pkg::*; ();

    logic      cmd_valid;
    logic      cmd_ready;
    opcode_u   opcode;
    reg_addr_t addr;       // First operand
    byte_t     wdata;      // Second operand, writes only

    modport source (
        output cmd_valid, opcode, addr, wdata,
        input  cmd_ready
    );

    modport sink (
        input  cmd_valid, opcode, addr, wdata,
        output cmd_ready
    );

endinterface

// ==== logic/ext_regs.sv ====
// Interface register bank, holds the operand and delay timeout counts as six bytes
`timescale 1ns/10ps

module ext_regs import if_ext_pkg::*; #(
    parameter int unsigned OPDS_TIME_RST  = 1000,
    parameter int unsigned DELAY_TIME_RST = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  reg_addr_t         addr,
    input  byte_t             wdata,
    output byte_t             rdata,
    output logic [TIME_W-1:0] opds_time,
    output logic [TIME_W-1:0] delay_time
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opds_time  <= TIME_W'(OPDS_TIME_RST);
            delay_time <= TIME_W'(DELAY_TIME_RST);
        end else if (we) begin
            case (addr)
                A_OPDS_TIME_0:  opds_time[7:0]    <= wdata;
                A_OPDS_TIME_1:  opds_time[15:8]   <= wdata;
                A_OPDS_TIME_2:  opds_time[23:16]  <= wdata;
                A_DELAY_TIME_0: delay_time[7:0]   <= wdata;
                A_DELAY_TIME_1: delay_time[15:8]  <= wdata;
                A_DELAY_TIME_2: delay_time[23:16] <= wdata;
                default: ;      // No register there
            endcase
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        case (addr)
            A_OPDS_TIME_0:  rdata = opds_time[7:0];
            A_OPDS_TIME_1:  rdata = opds_time[15:8];
            A_OPDS_TIME_2:  rdata = opds_time[23:16];
            A_DELAY_TIME_0: rdata = delay_time[7:0];
            A_DELAY_TIME_1: rdata = delay_time[15:8];
            A_DELAY_TIME_2: rdata = delay_time[23:16];
            default:        rdata = 8'h00;
        endcase
    end

endmodule

// ==== logic/if_ext_pkg.sv ====
// Shared widths, opcodes, block offsets and response kinds, imported by every RTL file
package if_ext_pkg;

    // ----------------------------------------
    // Basic types
    // ----------------------------------------
    typedef logic [7:0] byte_t;
    typedef logic [7:0] reg_addr_t;
    typedef logic [9:0] bus_addr_t;     // Block offset above register address

    localparam int TIME_W = 24;         // Timeout count width

    // Opcode byte seen raw or split into code and operand count
    typedef union packed {
        byte_t raw;
        struct packed {
            logic [3:0] cmd_code;
            logic [3:0] opd_count;      // 1 for reads, 2 for writes
        } f;
    } opcode_u;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------
    localparam byte_t OPC_INTERREGW   = 8'h02;
    localparam byte_t OPC_INTERREGR   = 8'h11;
    localparam byte_t OPC_GLOBALREGW  = 8'h22;
    localparam byte_t OPC_GLOBALREGR  = 8'h31;
    localparam byte_t OPC_JPEGREGW    = 8'h42;
    localparam byte_t OPC_JPEGREGR    = 8'h51;
    localparam byte_t OPC_DISPLAYREGW = 8'h62;
    localparam byte_t OPC_DISPLAYREGR = 8'h71;
    localparam byte_t OPC_SENSREGW    = 8'h82;
    localparam byte_t OPC_SENSREGR    = 8'h91;

    // Block offsets on the bus
    localparam logic [1:0] B_GLOBAL  = 2'b00;
    localparam logic [1:0] B_JPEG    = 2'b01;
    localparam logic [1:0] B_SENS    = 2'b10;
    localparam logic [1:0] B_DISPLAY = 2'b11;

    // Interface registers, one little-endian byte each
    localparam reg_addr_t A_OPDS_TIME_0  = 8'h00;
    localparam reg_addr_t A_OPDS_TIME_1  = 8'h01;
    localparam reg_addr_t A_OPDS_TIME_2  = 8'h02;
    localparam reg_addr_t A_DELAY_TIME_0 = 8'h03;
    localparam reg_addr_t A_DELAY_TIME_1 = 8'h04;
    localparam reg_addr_t A_DELAY_TIME_2 = 8'h05;

    // Response kinds
    localparam logic [1:0] RESP_WRITE_OK = 2'd0;
    localparam logic [1:0] RESP_READ_OK  = 2'd1;
    localparam logic [1:0] RESP_TIMEOUT  = 2'd2;

endpackage

// ==== logic/proc_if_ext.sv ====
// Top level of the link command processor, joins collector, register bank, executor and sender
`timescale 1ns/10ps

module proc_if_ext import if_ext_pkg::*; #(
    parameter int unsigned OPDS_TIME_RST  = 1000,
    parameter int unsigned DELAY_TIME_RST = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    // Receive port
    input  logic      data_valid,
    input  logic      data_ready,
    input  byte_t     data_byte,
    output logic      get_data,
    // Transmit port
    input  logic      tx_full,
    output byte_t     ack_byte,
    output logic      ack_valid,
    // Wishbone classic master
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output bus_addr_t wb_adr,
    output byte_t     wb_wdata,
    input  byte_t     wb_rdata,
    input  logic      wb_ack
);

    // ----------------------------------------
    // Internal links
    // ----------------------------------------
    cmd_if  cmd_link ();
    resp_if resp_link ();

    logic              reg_we;
    reg_addr_t         reg_addr;
    byte_t             reg_wdata;
    byte_t             reg_rdata;
    logic [TIME_W-1:0] opds_time;
    logic [TIME_W-1:0] delay_time;

    cmd_collector u_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .data_byte  (data_byte),
        .get_data   (get_data),
        .opds_time  (opds_time),
        .cmd        (cmd_link)
    );

    ext_regs #(
        .OPDS_TIME_RST  (OPDS_TIME_RST),
        .DELAY_TIME_RST (DELAY_TIME_RST)
    ) u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (reg_we),
        .addr       (reg_addr),
        .wdata      (reg_wdata),
        .rdata      (reg_rdata),
        .opds_time  (opds_time),
        .delay_time (delay_time)
    );

    cmd_executor u_executor (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd_link),
        .resp       (resp_link),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .delay_time (delay_time),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack)
    );

    ack_sender u_sender (
        .clk       (clk),
        .rst_n     (rst_n),
        .resp      (resp_link),
        .tx_full   (tx_full),
        .ack_byte  (ack_byte),
        .ack_valid (ack_valid)
    );

endmodule

// ==== logic/resp_if.sv ====
// Response channel, connects the executor (source) to the acknowledgement sender (sink)
`timescale 1ns/10ps

interface resp_if import if_ext_pkg::*; ();

    logic       resp_valid;
    logic       resp_ready;
    logic [1:0] kind;      // RESP_* code
    byte_t      rdata;     // Only meaningful for reads

    modport source (
        output resp_valid, kind, rdata,
        input  resp_ready
    );

    modport sink (
        input  resp_valid, kind, rdata,
        output resp_ready
    );

endinterface

// ==== proc_if_ext.f ====
logic/if_ext_pkg.sv
logic/cmd_if.sv
logic/resp_if.sv
logic/cmd_collector.sv
logic/ext_regs.sv
logic/cmd_executor.sv
logic/ack_sender.sv
logic/proc_if_ext.sv
tb/tb_bus_model.sv
tb/proc_if_ext_props.sv
tb/tb_proc_if_ext.sv

// ==== tb/proc_if_ext_props.sv ====
// Protocol assertions that are bound to the command processor top level in simulation
`timescale 1ns/10ps

module proc_if_ext_props import if_ext_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              get_data,
    input logic              tx_full,
    input logic              ack_valid,
    input logic              wb_cyc,
    input logic              wb_stb,
    input logic              wb_ack,
    input logic [TIME_W-1:0] delay_time
);

    logic [TIME_W-1:0] cyc_len;     // Cycles the current bus cycle has been open
    int                fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cyc_len <= '0;
        else if (wb_cyc)
            cyc_len <= cyc_len + 1'b1;
        else
            cyc_len <= '0;
    end

    // ----------------------------------------
    // Bus and link rules
    // ----------------------------------------
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            fail_count++;
        end

    ack_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        ack_valid |-> !tx_full)
        else begin
            $error("ack_valid while tx_full is high");
            fail_count++;
        end

    get_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        get_data |=> !get_data)
        else begin
            $error("get_data high for two cycles in a row");
            fail_count++;
        end

    // Cycle held until the target answers or the delay count runs out
    cyc_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack && cyc_len != delay_time) |=> wb_cyc)
        else begin
            $error("wb_cyc dropped before wb_ack or the delay timeout");
            fail_count++;
        end

endmodule

bind proc_if_ext proc_if_ext_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .get_data   (get_data),
    .tx_full    (tx_full),
    .ack_valid  (ack_valid),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .delay_time (delay_time)
);

// ==== tb/tb_bus_model.sv ====
// Wishbone target model for the testbench, 1024-byte memory answering after two cycles
`timescale 1ns/10ps

module tb_bus_model import if_ext_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  bus_addr_t wb_adr,
    input  byte_t     wb_wdata,
    output byte_t     wb_rdata,
    output logic      wb_ack,
    output bus_addr_t last_adr
);

    localparam bus_addr_t DEAD_ADR = 10'h2FF;   // Never acknowledged

    byte_t      mem [1024];
    logic [1:0] wait_cnt;

    initial begin
        bit [9:0] a;
        for (int i = 0; i < 1024; i++) begin
            a      = 10'(i);
            mem[i] = a[7:0] ^ {4{a[9:8]}};   // Pattern over all ten address bits
        end
        wb_ack   = 1'b0;
        wb_rdata = 8'h00;
        wait_cnt = 2'd0;
        last_adr = '0;
    end

    // Outputs change on the falling edge only
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack   = 1'b0;
            wait_cnt = 2'd0;
        end else begin
            wb_ack = 1'b0;
            if (wb_cyc && wb_stb) begin
                last_adr = wb_adr;
                if (wb_adr == DEAD_ADR) begin
                    wait_cnt = 2'd0;
                end else if (wait_cnt == 2'd1) begin
                    wb_ack   = 1'b1;            // Second cycle of the access
                    wait_cnt = 2'd0;
                    if (wb_we)
                        mem[wb_adr] = wb_wdata;
                    else
                        wb_rdata = mem[wb_adr];
                end else begin
                    wait_cnt = wait_cnt + 2'd1;
                end
            end else begin
                wait_cnt = 2'd0;
            end
        end
    end

endmodule

// ==== tb/tb_proc_if_ext.sv ====
// Directed testbench and simulation top that drives the command processor and checks its acks
`timescale 1ns/10ps

module tb_proc_if_ext import if_ext_pkg::*; ();

    localparam int OPDS_TIME   = 100;   // Short operand timeout for the pause test
    localparam int ACK_WAIT    = 500;   // Longest wait for one acknowledgement
    localparam int N_ACKS      = 18;
    localparam int CYCLE_LIMIT = (N_ACKS * ACK_WAIT + 1000) * 2;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      data_valid;
    logic      data_ready;
    byte_t     data_byte;
    logic      get_data;
    logic      tx_full;
    byte_t     ack_byte;
    logic      ack_valid;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    bus_addr_t wb_adr;
    byte_t     wb_wdata;
    byte_t     wb_rdata;
    logic      wb_ack;
    bus_addr_t last_adr;

    byte_t       rx_q [$];          // Bytes waiting on the link
    byte_t       ack_q [$];         // Bytes seen on the transmit port
    byte_t       got_q [$];
    int          rx_delay = 0;
    bit          bp_on = 1'b0;      // Random tx_full when set
    int          errors = 0;
    int          err_mark = 0;
    int          asrt_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    string       cur_test;

    proc_if_ext #(
        .OPDS_TIME_RST  (OPDS_TIME),
        .DELAY_TIME_RST (64)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .data_byte  (data_byte),
        .get_data   (get_data),
        .tx_full    (tx_full),
        .ack_byte   (ack_byte),
        .ack_valid  (ack_valid),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack)
    );

    tb_bus_model bus (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .last_adr (last_adr)
    );

    always #50 clk = ~clk;

    // ----------------------------------------
    // Receive link and tx_full on the falling edge
    // ----------------------------------------
    initial begin
        void'($urandom(32'h16f0e4ea));
        forever begin
            @(negedge clk);
            data_ready = 1'b0;
            if (rx_delay != 0) begin
                rx_delay = rx_delay - 1;
                if (rx_delay == 0) begin
                    data_ready = 1'b1;
                    data_byte  = rx_q.pop_front();
                end
            end else if (get_data) begin
                rx_delay = $urandom_range(3, 1);    // Answer 1 to 3 cycles later
            end
            data_valid = (rx_q.size() != 0);
            tx_full    = bp_on ? ($urandom_range(1, 0) != 0) : 1'b0;
        end
    end

    // Transmit monitor and run limit
    always @(posedge clk) begin
        if (ack_valid)
            ack_q.push_back(ack_byte);
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after reaching the limit of %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h in %s", name, got, exp, cur_test);
            errors++;
        end
    endtask

    task automatic check_adr(input string name, input bus_addr_t got, input bus_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h in %s", name, got, exp, cur_test);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_mark  = errors;
        asrt_mark = UUT.u_props.fail_count;
    endtask

    task automatic end_test();
        int asrt_new;
        asrt_new = UUT.u_props.fail_count - asrt_mark;
        tests_run++;
        if (asrt_new != 0) begin
            $display("%0d protocol assertions failed in %s", asrt_new, cur_test);
            errors += asrt_new;
        end
        if (errors == err_mark) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", cur_test, errors - err_mark);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_byte(input byte_t b);
        rx_q.push_back(b);
    endtask

    task automatic send_write(input byte_t op, input reg_addr_t a, input byte_t d);
        send_byte(op);
        send_byte(a);
        send_byte(d);
    endtask

    task automatic send_read(input byte_t op, input reg_addr_t a);
        send_byte(op);
        send_byte(a);
    endtask

    // Gathers transmit bytes up to and including LF
    task automatic collect_ack(output bit ok);
        int    waited;
        bit    found;
        byte_t b;
        got_q.delete();
        waited = 0;
        found  = 1'b0;
        while (!found && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
            while (ack_q.size() > 0 && !found) begin
                b = ack_q.pop_front();
                got_q.push_back(b);
                if (b == 8'h0A)
                    found = 1'b1;
            end
        end
        ok = found;
    endtask

    task automatic expect_ack(input string text, input bit with_data, input byte_t data);
        byte_t exp_q [$];
        bit    ok;
        for (int i = 0; i < text.len(); i++)
            exp_q.push_back(text[i]);
        if (with_data)
            exp_q.push_back(data);  // Raw byte after the colon
        exp_q.push_back(8'h0D);
        exp_q.push_back(8'h0A);
        collect_ack(ok);
        if (!ok) begin
            $display("no complete acknowledgement for %s within %0d cycles", text, ACK_WAIT);
            errors++;
        end else if (got_q.size() != exp_q.size()) begin
            $display("acknowledgement for %s has %0d bytes instead of %0d",
                     text, got_q.size(), exp_q.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_q.size(); i++)
                check_byte("ack_byte", got_q[i], exp_q[i]);
        end
    endtask

    task automatic expect_silence(input string what);
        if (ack_q.size() != 0) begin
            $display("%0d ack bytes appeared after %s", ack_q.size(), what);
            errors++;
            ack_q.delete();
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic internal_reg_access();
        begin_test("internal registers");
        send_write(OPC_INTERREGW, A_DELAY_TIME_0, 8'h20);
        expect_ack("WRITE+OK", 1'b0, 8'h00);
        send_read(OPC_INTERREGR, A_DELAY_TIME_0);
        expect_ack("READ+OK:", 1'b1, 8'h20);
        send_read(OPC_INTERREGR, 8'h40);        // Unmapped address reads zero
        expect_ack("READ+OK:", 1'b1, 8'h00);
        end_test();
    endtask

    task automatic bus_block_access();
        byte_t      wr_op [4] = '{OPC_GLOBALREGW, OPC_JPEGREGW, OPC_DISPLAYREGW, OPC_SENSREGW};
        byte_t      rd_op [4] = '{OPC_GLOBALREGR, OPC_JPEGREGR, OPC_DISPLAYREGR, OPC_SENSREGR};
        logic [1:0] off [4]   = '{B_GLOBAL, B_JPEG, B_DISPLAY, B_SENS};
        byte_t      val [4]   = '{8'hA1, 8'hB2, 8'hC3, 8'hD4};
        begin_test("bus blocks");
        for (int k = 0; k < 4; k++) begin
            send_write(wr_op[k], 8'h15, val[k]);
            expect_ack("WRITE+OK", 1'b0, 8'h00);
            check_adr("wb_adr", last_adr, {off[k], 8'h15});
            send_read(rd_op[k], 8'h15);
            expect_ack("READ+OK:", 1'b1, val[k]);
            check_adr("wb_adr", last_adr, {off[k], 8'h15});
        end
        end_test();
    endtask

    task automatic bus_timeout();
        begin_test("bus timeout");
        send_write(OPC_INTERREGW, A_DELAY_TIME_0, 8'h10);
        expect_ack("WRITE+OK", 1'b0, 8'h00);
        send_read(OPC_SENSREGR, 8'hFF);         // Dead address in the sensor block
        expect_ack("TIMEOUT", 1'b0, 8'h00);
        check_adr("wb_adr", last_adr, 10'h2FF);
        if (wb_cyc) begin
            $display("bus cycle still open after the delay timeout");
            errors++;
        end
        end_test();
    endtask

    task automatic discard_cases();
        begin_test("discard");
        send_byte(8'h55);
        wait_cycles(40);
        expect_silence("unknown opcode 0x55");
        send_read(OPC_GLOBALREGR, 8'h15);
        expect_ack("READ+OK:", 1'b1, 8'hA1);
        send_byte(OPC_JPEGREGR);                // Operand never follows
        wait_cycles(OPDS_TIME + 50);
        expect_silence("an opcode left without operands");
        send_read(OPC_JPEGREGR, 8'h15);
        expect_ack("READ+OK:", 1'b1, 8'hB2);
        end_test();
    endtask

    task automatic back_pressure();
        int waited;
        begin_test("back pressure");
        bp_on = 1'b1;
        send_read(OPC_DISPLAYREGR, 8'h15);
        waited = 0;
        while (ack_q.size() == 0 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack_q.size() == 0) begin
            $display("transmission of the first acknowledgement never started");
            errors++;
        end
        send_write(OPC_SENSREGW, 8'h15, 8'h5E); // Sent while the first ack is going out
        expect_ack("READ+OK:", 1'b1, 8'hC3);
        expect_ack("WRITE+OK", 1'b0, 8'h00);
        send_read(OPC_SENSREGR, 8'h15);
        expect_ack("READ+OK:", 1'b1, 8'h5E);
        bp_on = 1'b0;
        end_test();
    endtask

    initial begin
        rst_n      = 1'b0;
        data_valid = 1'b0;
        data_ready = 1'b0;
        data_byte  = 8'h00;
        tx_full    = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        wait_cycles(2);

        internal_reg_access();
        bus_block_access();
        bus_timeout();
        discard_cases();
        back_pressure();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
